// File: calc_top.f
+incdir+hw
hw/calc_pkg.sv
hw/calc_bypass.sv
hw/calc_pipe_int.sv
hw/calc_pipe_mul.sv
hw/calc_completion.sv
hw/calc_issue.sv
hw/calc_top.sv
bench/tb_clock.sv
bench/tb_calc_checker.sv
bench/tb_calc_top.sv

// File: run.sh
#!/bin/sh
# Builds and runs the calc_top simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f calc_top.f \
  --top-module tb_calc_top \
  --Mdir obj_dir \
  -o tb_calc_top_sim

out=$(./obj_dir/tb_calc_top_sim)
echo "$out"

echo "$out" | grep -qx "sim passed"

// File: bench/tb_calc_top.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module tb_calc_top;

  logic                            clk;
  logic                            arst_n;
  logic                            dispatch_v_i;
  calc_pkg::calc_op_e              dispatch_op_i;
  logic [`CALC_REG_ADDR_WIDTH-1:0] dispatch_rs1_addr_i;
  logic [`CALC_REG_ADDR_WIDTH-1:0] dispatch_rs2_addr_i;
  logic [`CALC_DATA_WIDTH-1:0]     dispatch_rs1_i;
  logic [`CALC_DATA_WIDTH-1:0]     dispatch_rs2_i;
  logic [`CALC_REG_ADDR_WIDTH-1:0] dispatch_rd_addr_i;
  logic                            dispatch_irf_w_v_i;
  logic                            flush_i;
  logic                            iwb_v_o;
  logic [`CALC_REG_ADDR_WIDTH-1:0] iwb_addr_o;
  logic [`CALC_DATA_WIDTH-1:0]     iwb_data_o;

  int mismatch_cnt;
  int unexpected_cnt;
  int missing_cnt;
  int pending;
  int other_cnt = 0;
  int cyc = 0;
  int flush_cnt = 0;

  // Small register pool so that dependencies are frequent
  logic [31:0] arch_rf[8];
  logic [31:0] model_rf[8];
  logic [31:0] hist[4][8];
  int          last_mul_e0[8];

  tb_clock clock_gen (.clk_o(clk), .arst_n_o(arst_n));

  calc_top dut
    (.clk_i(clk), .arst_n_i(arst_n)
     , .dispatch_v_i(dispatch_v_i), .dispatch_op_i(dispatch_op_i)
     , .dispatch_rs1_addr_i(dispatch_rs1_addr_i), .dispatch_rs2_addr_i(dispatch_rs2_addr_i)
     , .dispatch_rs1_i(dispatch_rs1_i), .dispatch_rs2_i(dispatch_rs2_i)
     , .dispatch_rd_addr_i(dispatch_rd_addr_i), .dispatch_irf_w_v_i(dispatch_irf_w_v_i)
     , .flush_i(flush_i)
     , .iwb_v_o(iwb_v_o), .iwb_addr_o(iwb_addr_o), .iwb_data_o(iwb_data_o)
    );

  tb_calc_checker wb_check
    (.clk_i(clk), .arst_n_i(arst_n), .cyc_i(cyc)
     , .iwb_v_i(iwb_v_o), .iwb_addr_i(iwb_addr_o), .iwb_data_i(iwb_data_o)
     , .mismatch_cnt_o(mismatch_cnt), .unexpected_cnt_o(unexpected_cnt)
     , .missing_cnt_o(missing_cnt), .pending_o(pending)
    );

  always @(posedge clk)
    cyc <= cyc + 1;

  function automatic logic [31:0] expected_result(input calc_pkg::calc_op_e op,
                                                  input logic [31:0] a, input logic [31:0] b);
    logic [63:0] prod;
    prod = {32'b0, a} * {32'b0, b};
    case (op)
      calc_pkg::e_op_add: return a + b;
      calc_pkg::e_op_sub: return a - b;
      calc_pkg::e_op_and: return a & b;
      calc_pkg::e_op_or:  return a | b;
      calc_pkg::e_op_xor: return a ^ b;
      calc_pkg::e_op_sll: return a << b[4:0];
      calc_pkg::e_op_srl: return a >> b[4:0];
      calc_pkg::e_op_slt: return {31'b0, $signed(a) < $signed(b)};
      default:            return prod[31:0];
    endcase
  endfunction

  // One edge; the architectural file follows observed writebacks
  task automatic tick();
    @(posedge clk);
    if (iwb_v_o && (iwb_addr_o != '0))
      arch_rf[iwb_addr_o[2:0]] = iwb_data_o;
  endtask

  // Draws the instruction sampled at the next edge, e0
  task automatic drive_random(input int e0);
    logic [31:0]        r;
    logic               v;
    logic               wen;
    logic               flush;
    logic [2:0]         rs1;
    logic [2:0]         rs2;
    logic [2:0]         rd;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        res;
    logic [1:0]         slot;
    calc_pkg::calc_op_e op;
    for (int i = 0; i < 8; i++)
      hist[e0 % 4][i] = model_rf[i];
    r   = $urandom;
    v   = (r[1:0] != 2'b00);
    wen = (r[4:2] != 3'b000);
    rs1 = r[7:5];
    rs2 = r[10:8];
    rd  = r[13:11];
    r   = $urandom;
    if ((r % 5) == 0)
      op = calc_pkg::e_op_mul;
    else
      op = calc_pkg::calc_op_e'({1'b0, r[10:8]});
    flush = (r[20:16] == 5'd0);
    // Bubble while a mul source is not yet forwardable
    if ((e0 - last_mul_e0[rs1] < 3) || (e0 - last_mul_e0[rs2] < 3))
      v = 1'b0;
    if (v)
    begin
      a   = (rs1 == 3'd0) ? 32'd0 : model_rf[rs1];
      b   = (rs2 == 3'd0) ? 32'd0 : model_rf[rs2];
      res = expected_result(op, a, b);
      if (wen)
      begin
        wb_check.push_expected({2'b0, rd}, res, e0);
        if (rd != 3'd0)
          model_rf[rd] = res;
        if (op == calc_pkg::e_op_mul)
          last_mul_e0[rd] = e0;
      end
    end
    dispatch_v_i        <= v;
    dispatch_op_i       <= op;
    dispatch_rs1_addr_i <= {2'b0, rs1};
    dispatch_rs2_addr_i <= {2'b0, rs2};
    dispatch_rs1_i      <= arch_rf[rs1];
    dispatch_rs2_i      <= arch_rf[rs2];
    dispatch_rd_addr_i  <= {2'b0, rd};
    dispatch_irf_w_v_i  <= wen;
    flush_i             <= flush;
    if (flush)
    begin
      // Back to the state before e0-2, which the killed slots now share too
      slot = 2'(e0 - 2);
      for (int i = 0; i < 8; i++)
      begin
        model_rf[i] = hist[slot][i];
        for (int j = 0; j < 4; j++)
          hist[j][i] = model_rf[i];
      end
      wb_check.drop_from(e0 - 2);
      flush_cnt++;
    end
  endtask

  initial
  begin
    int k;
    void'($urandom(32'h8f6));
    dispatch_v_i        = 1'b0;
    dispatch_op_i       = calc_pkg::e_op_add;
    dispatch_rs1_addr_i = '0;
    dispatch_rs2_addr_i = '0;
    dispatch_rs1_i      = '0;
    dispatch_rs2_i      = '0;
    dispatch_rd_addr_i  = '0;
    dispatch_irf_w_v_i  = 1'b0;
    flush_i             = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      arch_rf[i]     = (i == 0) ? 32'd0 : $urandom;
      model_rf[i]    = arch_rf[i];
      last_mul_e0[i] = -100;
      for (int j = 0; j < 4; j++)
        hist[j][i] = arch_rf[i];
    end

    for (k = 0; (k < 20) && (arst_n !== 1'b1); k++)
      @(posedge clk);
    if (arst_n !== 1'b1)
    begin
      $display("Reset was never released");
      other_cnt++;
    end
    else
    begin
      // Idle pipe must stay quiet
      repeat (10) tick();
      for (k = 0; k < 3000; k++)
      begin
        tick();
        drive_random(cyc + 2);
      end
      // Last drawn instruction still has to be sampled
      tick();
      dispatch_v_i <= 1'b0;
      flush_i      <= 1'b0;
      for (k = 0; (k < 60) && (pending != 0); k++)
        tick();
      if (pending != 0)
      begin
        $display("Writeback queue did not drain, %0d entries left", pending);
        other_cnt++;
      end
      repeat (5) tick();
    end

    $display("errors: mismatch %0d, unexpected %0d, missing %0d, other %0d (flushes %0d)",
             mismatch_cnt, unexpected_cnt, missing_cnt, other_cnt, flush_cnt);
    if ((mismatch_cnt + unexpected_cnt + missing_cnt + other_cnt) == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// File: bench/tb_calc_checker.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module tb_calc_checker
  (input  logic                            clk_i
   , input  logic                          arst_n_i
   , input  int                            cyc_i
   , input  logic                          iwb_v_i
   , input  logic [`CALC_REG_ADDR_WIDTH-1:0] iwb_addr_i
   , input  logic [`CALC_DATA_WIDTH-1:0]   iwb_data_i
   , output int                            mismatch_cnt_o
   , output int                            unexpected_cnt_o
   , output int                            missing_cnt_o
   , output int                            pending_o
  );

  logic [`CALC_REG_ADDR_WIDTH-1:0] addr_q[$];
  logic [`CALC_DATA_WIDTH-1:0]     data_q[$];
  int                              e0_q[$];
  int                              mismatch_cnt = 0;
  int                              unexpected_cnt = 0;
  int                              missing_cnt = 0;
  int                              idle_cnt = 0;

  assign mismatch_cnt_o   = mismatch_cnt;
  assign unexpected_cnt_o = unexpected_cnt;
  assign missing_cnt_o    = missing_cnt;
  assign pending_o        = addr_q.size();

  task automatic push_expected(input logic [`CALC_REG_ADDR_WIDTH-1:0] addr,
                               input logic [`CALC_DATA_WIDTH-1:0] data, input int e0);
    addr_q.push_back(addr);
    data_q.push_back(data);
    e0_q.push_back(e0);
  endtask

  // Youngest entries sit at the back
  task automatic drop_from(input int e0_min);
    while ((e0_q.size() > 0) && (e0_q[e0_q.size()-1] >= e0_min))
    begin
      void'(addr_q.pop_back());
      void'(data_q.pop_back());
      void'(e0_q.pop_back());
    end
  endtask

  always @(posedge clk_i)
  begin
    if (arst_n_i)
    begin
      if (iwb_v_i)
      begin
        idle_cnt = 0;
        if (addr_q.size() == 0)
        begin
          $display("Writeback to x%0d at %0t with nothing outstanding", iwb_addr_i, $time);
          unexpected_cnt++;
        end
        else
        begin
          if ((iwb_addr_i !== addr_q[0]) || (iwb_data_i !== data_q[0])
              || (cyc_i + 1 != e0_q[0] + 5))
          begin
            $display("FAIL %0t: wb x%0d=%h edge %0d, expected x%0d=%h edge %0d",
                     $time, iwb_addr_i, iwb_data_i, cyc_i + 1,
                     addr_q[0], data_q[0], e0_q[0] + 5);
            mismatch_cnt++;
          end
          void'(addr_q.pop_front());
          void'(data_q.pop_front());
          void'(e0_q.pop_front());
        end
      end
      else if (addr_q.size() > 0)
      begin
        idle_cnt++;
        if (idle_cnt > 20)
        begin
          $display("Writeback to x%0d dispatched at edge %0d never arrived",
                   addr_q[0], e0_q[0]);
          missing_cnt++;
          void'(addr_q.pop_front());
          void'(data_q.pop_front());
          void'(e0_q.pop_front());
          idle_cnt = 0;
        end
      end
      else
        idle_cnt = 0;
    end
  end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock
  (output logic clk_o
   , output logic arst_n_o
  );

  initial
  begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Reset held for 4 rising edges, released away from the edge
  initial
  begin
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// File: hw/calc_top.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module calc_top
  (input  logic                                clk_i
   , input  logic                              arst_n_i

   , input  logic                              dispatch_v_i
   , input  calc_pkg::calc_op_e                dispatch_op_i
   , input  logic [`CALC_REG_ADDR_WIDTH-1:0]   dispatch_rs1_addr_i
   , input  logic [`CALC_REG_ADDR_WIDTH-1:0]   dispatch_rs2_addr_i
   , input  logic [`CALC_DATA_WIDTH-1:0]       dispatch_rs1_i
   , input  logic [`CALC_DATA_WIDTH-1:0]       dispatch_rs2_i
   , input  logic [`CALC_REG_ADDR_WIDTH-1:0]   dispatch_rd_addr_i
   , input  logic                              dispatch_irf_w_v_i

   , input  logic                              flush_i

   , output logic                              iwb_v_o
   , output logic [`CALC_REG_ADDR_WIDTH-1:0]   iwb_addr_o
   , output logic [`CALC_DATA_WIDTH-1:0]       iwb_data_o
  );

  calc_pkg::calc_resv_s                                    resv;
  logic [`CALC_DATA_WIDTH-1:0]                             int_data;
  logic [`CALC_DATA_WIDTH-1:0]                             mul_data;
  logic [`CALC_FWD_ELS-1:0]                                fwd_v;
  logic [`CALC_FWD_ELS-1:0][`CALC_REG_ADDR_WIDTH-1:0]      fwd_rd_addr;
  logic [`CALC_FWD_ELS-1:0][`CALC_DATA_WIDTH-1:0]          fwd_data;

  calc_issue issue
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .dispatch_v_i(dispatch_v_i)
     , .dispatch_op_i(dispatch_op_i)
     , .dispatch_rs1_addr_i(dispatch_rs1_addr_i)
     , .dispatch_rs2_addr_i(dispatch_rs2_addr_i)
     , .dispatch_rs1_i(dispatch_rs1_i)
     , .dispatch_rs2_i(dispatch_rs2_i)
     , .dispatch_rd_addr_i(dispatch_rd_addr_i)
     , .dispatch_irf_w_v_i(dispatch_irf_w_v_i)
     , .fwd_v_i(fwd_v)
     , .fwd_rd_addr_i(fwd_rd_addr)
     , .fwd_data_i(fwd_data)
     , .resv_o(resv)
    );

  calc_pipe_int pipe_int
    (.resv_i(resv)
     , .data_o(int_data)
    );

  calc_pipe_mul pipe_mul
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .resv_i(resv)
     , .data_o(mul_data)
    );

  calc_completion completion
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .resv_i(resv)
     , .int_data_i(int_data)
     , .mul_data_i(mul_data)
     , .flush_i(flush_i)
     , .fwd_v_o(fwd_v)
     , .fwd_rd_addr_o(fwd_rd_addr)
     , .fwd_data_o(fwd_data)
     , .iwb_v_o(iwb_v_o)
     , .iwb_addr_o(iwb_addr_o)
     , .iwb_data_o(iwb_data_o)
    );

endmodule

// File: hw/calc_issue.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module calc_issue
  (input  logic                                                clk_i
   , input  logic                                              arst_n_i

   , input  logic                                              dispatch_v_i
   , input  calc_pkg::calc_op_e                                dispatch_op_i
   , input  logic [`CALC_REG_ADDR_WIDTH-1:0]                   dispatch_rs1_addr_i
   , input  logic [`CALC_REG_ADDR_WIDTH-1:0]                   dispatch_rs2_addr_i
   , input  logic [`CALC_DATA_WIDTH-1:0]                       dispatch_rs1_i
   , input  logic [`CALC_DATA_WIDTH-1:0]                       dispatch_rs2_i
   , input  logic [`CALC_REG_ADDR_WIDTH-1:0]                   dispatch_rd_addr_i
   , input  logic                                              dispatch_irf_w_v_i

   , input  logic [`CALC_FWD_ELS-1:0]                          fwd_v_i
   , input  logic [`CALC_FWD_ELS-1:0][`CALC_REG_ADDR_WIDTH-1:0] fwd_rd_addr_i
   , input  logic [`CALC_FWD_ELS-1:0][`CALC_DATA_WIDTH-1:0]    fwd_data_i

   , output calc_pkg::calc_resv_s                              resv_o
  );

  logic [`CALC_DATA_WIDTH-1:0] bypass_rs1;
  logic [`CALC_DATA_WIDTH-1:0] bypass_rs2;
  calc_pkg::calc_resv_s        resv_n;
  calc_pkg::calc_resv_s        resv_q;
  logic                        resv_v_r;

  calc_bypass
    #(.els_p(2)
      , .zero_x0_p(1'b1)
     )
    int_bypass
    (.id_addr_i({dispatch_rs2_addr_i, dispatch_rs1_addr_i})
     , .id_data_i({dispatch_rs2_i, dispatch_rs1_i})
     , .fwd_v_i(fwd_v_i)
     , .fwd_rd_addr_i(fwd_rd_addr_i)
     , .fwd_data_i(fwd_data_i)
     , .bypass_o({bypass_rs2, bypass_rs1})
    );

  always_comb
  begin
    resv_n.v       = dispatch_v_i;
    resv_n.op      = dispatch_op_i;
    resv_n.pipe    = (dispatch_op_i == calc_pkg::e_op_mul) ? calc_pkg::e_pipe_mul
                                                           : calc_pkg::e_pipe_int;
    resv_n.rd_addr = dispatch_rd_addr_i;
    resv_n.irf_w_v = dispatch_irf_w_v_i;
    resv_n.rs1     = bypass_rs1;
    resv_n.rs2     = bypass_rs2;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      resv_v_r <= 1'b0;
    else
      resv_v_r <= resv_n.v;
  end

  always_ff @(posedge clk_i)
    resv_q <= resv_n;

  always_comb
  begin
    resv_o   = resv_q;
    resv_o.v = resv_v_r;
  end

  a_op_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dispatch_v_i |-> (!$isunknown(dispatch_op_i) && (dispatch_op_i <= calc_pkg::e_op_mul)))
    else $error("dispatch with unknown op %0d", dispatch_op_i);

endmodule

// File: hw/calc_completion.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module calc_completion
  (input  logic                                                clk_i
   , input  logic                                              arst_n_i

   , input  calc_pkg::calc_resv_s                              resv_i
   , input  logic [`CALC_DATA_WIDTH-1:0]                       int_data_i
   , input  logic [`CALC_DATA_WIDTH-1:0]                       mul_data_i
   , input  logic                                              flush_i

   , output logic [`CALC_FWD_ELS-1:0]                          fwd_v_o
   , output logic [`CALC_FWD_ELS-1:0][`CALC_REG_ADDR_WIDTH-1:0] fwd_rd_addr_o
   , output logic [`CALC_FWD_ELS-1:0][`CALC_DATA_WIDTH-1:0]    fwd_data_o

   , output logic                                              iwb_v_o
   , output logic [`CALC_REG_ADDR_WIDTH-1:0]                   iwb_addr_o
   , output logic [`CALC_DATA_WIDTH-1:0]                       iwb_data_o
  );

  localparam int els_lp      = `CALC_PIPE_STAGE_ELS;
  localparam int mul_slot_lp = `CALC_MUL_LATENCY;

  calc_pkg::calc_stage_s [els_lp:1]                          stage_r;
  calc_pkg::calc_stage_s [els_lp+1:1]                        stage_n;
  logic                  [els_lp:1][`CALC_DATA_WIDTH-1:0]    data_r;
  logic                  [els_lp+1:1][`CALC_DATA_WIDTH-1:0]  data_n;
  // Bit 0 follows the instruction sitting in the reservation register
  logic                  [els_lp:0]                          poison_r;
  logic                  [els_lp+1:1]                        poison_n;
  logic                                                      int_claim;
  logic                                                      mul_claim;

  assign int_claim = resv_i.v && (resv_i.pipe == calc_pkg::e_pipe_int);
  assign mul_claim = stage_r[mul_slot_lp-1].v
                     && (stage_r[mul_slot_lp-1].pipe == calc_pkg::e_pipe_mul);

  always_comb
  begin
    stage_n[1].v       = resv_i.v;
    stage_n[1].pipe    = resv_i.pipe;
    stage_n[1].rd_addr = resv_i.rd_addr;
    stage_n[1].irf_w_v = resv_i.irf_w_v;
    for (int i = 2; i <= els_lp+1; i++)
      stage_n[i] = stage_r[i-1];
  end

  // Results merge in where each pipe finishes
  always_comb
  begin
    data_n[1] = int_claim ? int_data_i : '0;
    for (int i = 2; i <= els_lp+1; i++)
    begin
      if ((i == mul_slot_lp) && mul_claim)
        data_n[i] = mul_data_i;
      else
        data_n[i] = data_r[i-1];
    end
  end

  always_comb
  begin
    for (int i = 1; i <= els_lp+1; i++)
      poison_n[i] = poison_r[i-1] | (flush_i && (i < `CALC_POISON_STAGES));
    // Bubbles never write back
    poison_n[1] = poison_n[1] | ~resv_i.v;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      stage_r  <= '0;
      poison_r <= '0;
    end
    else
    begin
      stage_r  <= stage_n[els_lp:1];
      poison_r <= {poison_n[els_lp:1], flush_i};
    end
  end

  always_ff @(posedge clk_i)
    data_r <= data_n[els_lp:1];

  // A mul is only visible once its product has merged
  always_comb
  begin
    for (int s = 0; s < `CALC_FWD_ELS; s++)
    begin
      fwd_v_o[s]       = stage_n[s+1].v & stage_n[s+1].irf_w_v & ~poison_n[s+1]
                         & ((stage_n[s+1].pipe == calc_pkg::e_pipe_int)
                            || ((s + 1) >= mul_slot_lp));
      fwd_rd_addr_o[s] = stage_n[s+1].rd_addr;
      fwd_data_o[s]    = data_n[s+1];
    end
  end

  assign iwb_v_o    = stage_r[els_lp].v & stage_r[els_lp].irf_w_v & ~poison_r[els_lp];
  assign iwb_addr_o = stage_r[els_lp].rd_addr;
  assign iwb_data_o = data_r[els_lp];

  // The int merge point only ever sees a result for an int instruction
  a_int_merge: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !int_claim |-> (int_data_i == '0))
    else $error("int result offered without an int instruction in the reservation");

endmodule

// File: hw/calc_pipe_mul.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module calc_pipe_mul
  (input  logic                          clk_i
   , input  logic                        arst_n_i
   , input  calc_pkg::calc_resv_s        resv_i
   , output logic [`CALC_DATA_WIDTH-1:0] data_o
  );

  localparam int half_lp = `CALC_DATA_WIDTH / 2;

  logic                        own;
  logic                        op_v_r;
  logic                        pp_v_r;
  logic [`CALC_DATA_WIDTH-1:0] a_r;
  logic [`CALC_DATA_WIDTH-1:0] b_r;
  logic [`CALC_DATA_WIDTH-1:0] pp_lo_r;
  logic [half_lp-1:0]          pp_hi_r;

  assign own = resv_i.v && (resv_i.pipe == calc_pkg::e_pipe_mul);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      op_v_r <= 1'b0;
      pp_v_r <= 1'b0;
    end
    else
    begin
      op_v_r <= own;
      pp_v_r <= op_v_r;
    end
  end

  // Low half of b against all of a
  // The high half of b only reaches the upper 16 bits
  always_ff @(posedge clk_i)
  begin
    if (own)
    begin
      a_r <= resv_i.rs1;
      b_r <= resv_i.rs2;
    end
    if (op_v_r)
    begin
      pp_lo_r <= a_r * {{half_lp{1'b0}}, b_r[half_lp-1:0]};
      pp_hi_r <= a_r[half_lp-1:0] * b_r[`CALC_DATA_WIDTH-1:half_lp];
    end
  end

  assign data_o = pp_lo_r + {pp_hi_r, {half_lp{1'b0}}};

  // Partial products must rebuild the low word of the full product
  a_pp_product: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pp_v_r |-> (data_o == $past(a_r * b_r)))
    else $error("mul product does not match its operands");

endmodule

// File: hw/calc_pipe_int.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module calc_pipe_int
  (input  calc_pkg::calc_resv_s        resv_i
   , output logic [`CALC_DATA_WIDTH-1:0] data_o
  );

  localparam int shamt_width_lp = $clog2(`CALC_DATA_WIDTH);

  logic                        own;
  logic                        lt;
  logic [shamt_width_lp-1:0]   shamt;
  logic [`CALC_DATA_WIDTH-1:0] result;

  assign own   = resv_i.v && (resv_i.pipe == calc_pkg::e_pipe_int);
  assign shamt = resv_i.rs2[shamt_width_lp-1:0];
  assign lt    = $signed(resv_i.rs1) < $signed(resv_i.rs2);

  always_comb
  begin
    case (resv_i.op)
      calc_pkg::e_op_add: result = resv_i.rs1 + resv_i.rs2;
      calc_pkg::e_op_sub: result = resv_i.rs1 - resv_i.rs2;
      calc_pkg::e_op_and: result = resv_i.rs1 & resv_i.rs2;
      calc_pkg::e_op_or:  result = resv_i.rs1 | resv_i.rs2;
      calc_pkg::e_op_xor: result = resv_i.rs1 ^ resv_i.rs2;
      calc_pkg::e_op_sll: result = resv_i.rs1 << shamt;
      calc_pkg::e_op_srl: result = resv_i.rs1 >> shamt;
      calc_pkg::e_op_slt: result = {{(`CALC_DATA_WIDTH-1){1'b0}}, lt};
      // mul belongs to the other pipe
      default:            result = '0;
    endcase
  end

  assign data_o = own ? result : '0;

endmodule

// File: hw/calc_bypass.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module calc_bypass
  #(parameter int   els_p     = 2
    , parameter bit zero_x0_p = 1'b1
   )
  (input  logic [els_p-1:0][`CALC_REG_ADDR_WIDTH-1:0]          id_addr_i
   , input  logic [els_p-1:0][`CALC_DATA_WIDTH-1:0]            id_data_i

   , input  logic [`CALC_FWD_ELS-1:0]                          fwd_v_i
   , input  logic [`CALC_FWD_ELS-1:0][`CALC_REG_ADDR_WIDTH-1:0] fwd_rd_addr_i
   , input  logic [`CALC_FWD_ELS-1:0][`CALC_DATA_WIDTH-1:0]    fwd_data_i

   , output logic [els_p-1:0][`CALC_DATA_WIDTH-1:0]            bypass_o
  );

  // Tap 0 is the youngest in-flight instruction
  always_comb
  begin
    for (int e = 0; e < els_p; e++)
    begin
      bypass_o[e] = id_data_i[e];

      // Walk oldest to youngest, so the youngest match is the one that sticks
      for (int s = `CALC_FWD_ELS-1; s >= 0; s--)
      begin
        if (fwd_v_i[s] && (fwd_rd_addr_i[s] == id_addr_i[e]))
        begin
          bypass_o[e] = fwd_data_i[s];
        end
      end

      // x0 is hardwired
      if (zero_x0_p && (id_addr_i[e] == '0))
      begin
        bypass_o[e] = '0;
      end
    end
  end

endmodule

// File: hw/calc_pkg.sv
`include "calc_macros.svh"

package calc_pkg;

  typedef enum logic [3:0]
  {
    e_op_add = 4'd0
    , e_op_sub = 4'd1
    , e_op_and = 4'd2
    , e_op_or  = 4'd3
    , e_op_xor = 4'd4
    , e_op_sll = 4'd5
    , e_op_srl = 4'd6
    , e_op_slt = 4'd7
    , e_op_mul = 4'd8
  } calc_op_e;

  typedef enum logic
  {
    e_pipe_int = 1'b0
    , e_pipe_mul = 1'b1
  } calc_pipe_e;

  // What the completion pipe keeps per slot
  typedef struct packed
  {
    logic                            v;
    calc_pipe_e                      pipe;
    logic [`CALC_REG_ADDR_WIDTH-1:0] rd_addr;
    logic                            irf_w_v;
  } calc_stage_s;

  typedef struct packed
  {
    logic                            v;
    calc_op_e                        op;
    calc_pipe_e                      pipe;
    logic [`CALC_REG_ADDR_WIDTH-1:0] rd_addr;
    logic                            irf_w_v;
    logic [`CALC_DATA_WIDTH-1:0]     rs1;
    logic [`CALC_DATA_WIDTH-1:0]     rs2;
  } calc_resv_s;

endpackage

// File: hw/calc_macros.svh
`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// Datapath and register file
`define CALC_DATA_WIDTH     32
`define CALC_REG_ADDR_WIDTH 5

// Completion pipe shape
`define CALC_PIPE_STAGE_ELS 4
`define CALC_MUL_LATENCY    3

// Dispatch, reservation and slot 1
`define CALC_POISON_STAGES  3

// One forwarding tap per completion stage, plus the slot that is writing back
`define CALC_FWD_ELS (`CALC_PIPE_STAGE_ELS + 1)

`endif
